//--- sources.f
+incdir+design
+incdir+sim
design/img_pkg.sv
design/readout_pkg.sv
design/frame_bank_if.sv
design/frame_bank.sv
design/fletcher_checksum.sv
design/pixel_capture.sv
design/readout_sequencer.sv
design/img_controller.sv
sim/tb_img_controller.sv

//--- sim/img_check_tasks.svh
`ifndef IMG_CHECK_TASKS_SVH
`define IMG_CHECK_TASKS_SVH

// ========================================
// Compare tasks and failure reporting
// ========================================

task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
endtask

// Failures that are not a wrong value
task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    stop_on_failure();
endtask

task automatic check_word(input string test_name, input img_pkg::word_t expected,
                          input img_pkg::word_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_stat(input string test_name, input img_pkg::stat_t expected,
                          input img_pkg::stat_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected %0d, actual %0d", test_name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_count(input string test_name, input img_pkg::pixel_count_t expected,
                           input img_pkg::pixel_count_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected %0d, actual %0d", test_name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_checksum(input string test_name, input readout_pkg::checksum_t expected,
                              input readout_pkg::checksum_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        stop_on_failure();
    end
endtask

`endif

//--- sim/tb_img_controller.sv
`timescale 1ns/1ns
`include "img_macros.svh"

module tb_img_controller;

    localparam int NUM_TESTS      = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 3000;
    localparam int PAT_NONE       = 0;
    localparam int PAT_RAMP       = 1;
    localparam int PAT_EXTREME    = 2;
    localparam int PAT_RANDOM     = 3;
    localparam int PAT_FLAT       = 4;

    typedef struct {
        string                    name;
        img_pkg::bank_sel_t       bank;
        logic                     skip;
        logic                     thumb;
        logic [`HEADER_WIDTH-1:0] header;
        int                       pattern;
        int                       bp_percent;
    } test_row_t;

    logic                     clk;
    logic                     rst;
    logic                     cmd_capture;
    logic                     cmd_readout;
    img_pkg::bank_sel_t       cmd_bank;
    logic                     cmd_skip_count;
    logic [`HEADER_WIDTH-1:0] cmd_header;
    logic                     cmd_thumb;
    img_pkg::pixel_t          img_d;
    logic                     img_fv;
    logic                     img_lv;
    logic                     readout_start;
    logic                     readout_ready;
    logic                     readout_trigger;
    img_pkg::word_t           readout_data;
    logic                     readout_done;
    logic                     capture_done;
    img_pkg::pixel_count_t    capture_pixel_count;
    img_pkg::stat_t           capture_highlight_count;
    img_pkg::stat_t           capture_shadow_count;

    test_row_t                table_rows [NUM_TESTS];
    img_pkg::pixel_t          frame_px [`IMG_PIXEL_COUNT];
    img_pkg::pixel_t          bank_img [`BANK_COUNT][`IMG_PIXEL_COUNT];
    int                       cycle_count;

    `include "img_check_tasks.svh"

    img_controller dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hang guard
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                report_failure($sformatf("DUT hung, no finish after %0d cycles", cycle_count));
            end
        end
    end

    // ========================================
    // Reference rules
    // ========================================
    function automatic img_pkg::word_t pack_pixel(input img_pkg::pixel_t px);
        return img_pkg::word_t'((px % 256) * 256 + px / 256);
    endfunction

    function automatic img_pkg::word_t byte_swap(input img_pkg::word_t w);
        return img_pkg::word_t'((w % 256) * 256 + w / 256);
    endfunction

    function automatic bit in_thumbnail(input int addr);
        return ((addr % `IMG_WIDTH) % 8 < 2) && ((addr / `IMG_WIDTH) % 8 < 2);
    endfunction

    task automatic fill_frame(input int pattern);
        int x;
        int y;
        int k;
        for (int a = 0; a < `IMG_PIXEL_COUNT; a++) begin
            x = a % `IMG_WIDTH;
            y = a / `IMG_WIDTH;
            k = (y / 4) * 4 + x / 4;
            frame_px[a] = img_pkg::pixel_t'($urandom);
            if (pattern == PAT_RAMP) begin
                frame_px[a] = img_pkg::pixel_t'(a * 37 + 11);
            end else if (pattern == PAT_FLAT) begin
                frame_px[a] = 12'hFFF;
            end else if (pattern == PAT_EXTREME && x % 4 == 0 && y % 4 == 0) begin
                // Sampled spots cycle through highlight, shadow, mid grey
                if (k % 3 == 0) begin
                    frame_px[a] = 12'hFE0 | img_pkg::pixel_t'($urandom & 32'h1F);
                end else if (k % 3 == 1) begin
                    frame_px[a] = img_pkg::pixel_t'($urandom & 32'h1F);
                end else begin
                    frame_px[a] = 12'h7FF;
                end
            end
        end
    endtask

    // One frame on the pixel bus followed by a short gap with fv low
    task automatic drive_frame(output bit done_seen);
        done_seen = 1'b0;
        @(posedge clk);
        #2 img_fv = 1'b1;
        repeat (2) @(posedge clk);
        for (int y = 0; y < `IMG_HEIGHT; y++) begin
            for (int x = 0; x < `IMG_WIDTH; x++) begin
                @(posedge clk);
                #2 img_lv = 1'b1;
                img_d = frame_px[y * `IMG_WIDTH + x];
            end
            @(posedge clk);
            #2 img_lv = 1'b0;
            @(posedge clk);
        end
        @(posedge clk);
        #2 img_fv = 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (capture_done) done_seen = 1'b1;
        end
    endtask

    task automatic run_capture(input test_row_t row);
        bit             done_seen;
        img_pkg::stat_t exp_hi;
        img_pkg::stat_t exp_sh;
        img_pkg::pixel_t px;
        @(posedge clk);
        #2 cmd_capture = 1'b1;
        cmd_bank       = row.bank;
        cmd_skip_count = row.skip;
        @(posedge clk);
        #2 cmd_capture = 1'b0;
        for (int f = 0; f <= row.skip; f++) begin
            fill_frame((f < row.skip) ? PAT_FLAT : row.pattern);
            drive_frame(done_seen);
            if (f < row.skip && done_seen) begin
                report_failure({row.name, ": capture_done pulsed on a skipped frame"});
            end
        end
        if (!done_seen) report_failure({row.name, ": capture_done never pulsed"});
        exp_hi = '0;
        exp_sh = '0;
        // Top seven bits all ones means 0xFE0 and up, all zeros means below 0x020
        for (int y = 0; y < `IMG_HEIGHT; y += 4) begin
            for (int x = 0; x < `IMG_WIDTH; x += 4) begin
                px = frame_px[y * `IMG_WIDTH + x];
                if (px >= 12'hFE0) exp_hi++;
                else if (px < 12'h020) exp_sh++;
            end
        end
        bank_img[row.bank] = frame_px;
        check_count(row.name, img_pkg::pixel_count_t'(`IMG_PIXEL_COUNT), capture_pixel_count);
        check_stat(row.name, exp_hi, capture_highlight_count);
        check_stat(row.name, exp_sh, capture_shadow_count);
    endtask

    task automatic run_readout(input test_row_t row);
        img_pkg::word_t         exp_q[$];
        img_pkg::word_t         rx_q[$];
        readout_pkg::checksum_t exp_csum;
        int                     sum_a;
        int                     sum_b;
        int                     m;
        bit                     done;
        for (int i = 0; i < `HEADER_WORD_COUNT; i++) begin
            exp_q.push_back(row.header[`HEADER_WIDTH-1-16*i -: 16]);
        end
        for (int a = 0; a < `IMG_PIXEL_COUNT; a++) begin
            if (!row.thumb || in_thumbnail(a)) exp_q.push_back(pack_pixel(bank_img[row.bank][a]));
        end
        // Fletcher-32 over the little endian view of each word
        sum_a = 0;
        sum_b = 0;
        foreach (exp_q[i]) begin
            sum_a = (sum_a + byte_swap(exp_q[i])) % 65535;
            sum_b = (sum_b + sum_a) % 65535;
        end
        exp_csum = {byte_swap(img_pkg::word_t'(sum_a)), byte_swap(img_pkg::word_t'(sum_b))};

        @(posedge clk);
        #2 cmd_readout = 1'b1;
        cmd_bank   = row.bank;
        cmd_header = row.header;
        cmd_thumb  = row.thumb;
        @(negedge clk);
        if (readout_done !== 1'b0) report_failure({row.name, ": readout_done high at command"});
        @(posedge clk);
        #2 cmd_readout = 1'b0;
        @(negedge clk);
        if (readout_start !== 1'b1) report_failure({row.name, ": readout_start did not pulse"});
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2 readout_trigger = ($urandom % 100) >= row.bp_percent;
            @(negedge clk);
            if (readout_ready && readout_trigger) rx_q.push_back(readout_data);
            done = readout_done;
        end
        @(posedge clk);
        #2 readout_trigger = 1'b0;

        m = exp_q.size();
        if (rx_q.size() != m + `TRAILER_WORD_COUNT) begin
            report_failure($sformatf("%s: %0d words before readout_done, %0d expected",
                                     row.name, rx_q.size(), m + `TRAILER_WORD_COUNT));
        end
        for (int i = 0; i < m; i++) begin
            check_word($sformatf("%s word %0d", row.name, i), exp_q[i], rx_q[i]);
        end
        check_checksum({row.name, " checksum"}, exp_csum, {rx_q[m], rx_q[m+1]});
        for (int i = m + 2; i < m + `TRAILER_WORD_COUNT; i++) begin
            check_word($sformatf("%s padding %0d", row.name, i), '0, rx_q[i]);
        end
    endtask

    // ========================================
    // Stimulus table and main sequence
    // ========================================
    initial begin
        void'($urandom(32'h85fb9148));
        rst             = 1'b1;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_bank        = '0;
        cmd_skip_count  = 1'b0;
        cmd_header      = '0;
        cmd_thumb       = 1'b0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;

        //              name                 bank  skip  thumb header          pattern   bp
        table_rows[0] = '{"ramp_full_bank0", 1'b0, 1'b0, 1'b0,
                          64'h1234_5678_9ABC_DEF0, PAT_RAMP, 0};
        table_rows[1] = '{"extremes_full_bank1", 1'b1, 1'b0, 1'b0,
                          64'hA5A5_0001_FFFF_0000, PAT_EXTREME, 0};
        table_rows[2] = '{"reread_bank0", 1'b0, 1'b0, 1'b0,
                          64'h0F0F_F0F0_0102_0304, PAT_NONE, 0};
        table_rows[3] = '{"skip_one_bank0", 1'b0, 1'b1, 1'b0,
                          64'h0123_4567_89AB_CDEF, PAT_EXTREME, 0};
        table_rows[4] = '{"thumb_bank1", 1'b1, 1'b0, 1'b1,
                          64'h8000_7FFF_0080_FF00, PAT_RANDOM, 0};
        table_rows[5] = '{"backpressure_bank0", 1'b0, 1'b0, 1'b0,
                          64'h5555_AAAA_3C3C_C3C3, PAT_RANDOM, 50};
        table_rows[6] = '{"thumb_backpressure_bank1", 1'b1, 1'b0, 1'b1,
                          64'hFEDC_BA98_7654_3210, PAT_NONE, 70};

        repeat (16) @(posedge clk);
        #2 rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            if (table_rows[t].pattern != PAT_NONE) run_capture(table_rows[t]);
            run_readout(table_rows[t]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- design/img_controller.sv
`timescale 1ns/1ns
`include "img_macros.svh"

module img_controller (
    input  logic                     clk,
    input  logic                     rst,

    // Commands
    input  logic                     cmd_capture,
    input  logic                     cmd_readout,
    input  img_pkg::bank_sel_t       cmd_bank,
    input  logic                     cmd_skip_count,
    input  logic [`HEADER_WIDTH-1:0] cmd_header,
    input  logic                     cmd_thumb,

    // Pixel bus
    input  img_pkg::pixel_t          img_d,
    input  logic                     img_fv,
    input  logic                     img_lv,

    // Readout port
    output logic                     readout_start,
    output logic                     readout_ready,
    input  logic                     readout_trigger,
    output img_pkg::word_t           readout_data,
    output logic                     readout_done,

    // Status
    output logic                     capture_done,
    output img_pkg::pixel_count_t    capture_pixel_count,
    output img_pkg::stat_t           capture_highlight_count,
    output img_pkg::stat_t           capture_shadow_count
);

    frame_bank_if banks [`BANK_COUNT] ();

    pixel_capture u_capture (
        .clk                    (clk),
        .rst                    (rst),
        .cmd_capture            (cmd_capture),
        .cmd_bank               (cmd_bank),
        .cmd_skip_count         (cmd_skip_count),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .banks                  (banks),
        .capture_done           (capture_done),
        .capture_pixel_count    (capture_pixel_count),
        .capture_highlight_count(capture_highlight_count),
        .capture_shadow_count   (capture_shadow_count)
    );

    // ========================================
    // Frame banks
    // ========================================
    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
        frame_bank u_bank (
            .clk (clk),
            .port(banks[g])
        );
    end

    readout_sequencer u_readout (
        .clk            (clk),
        .rst            (rst),
        .cmd_readout    (cmd_readout),
        .cmd_bank       (cmd_bank),
        .cmd_header     (cmd_header),
        .cmd_thumb      (cmd_thumb),
        .banks          (banks),
        .readout_start  (readout_start),
        .readout_ready  (readout_ready),
        .readout_trigger(readout_trigger),
        .readout_data   (readout_data),
        .readout_done   (readout_done)
    );

endmodule

//--- design/readout_sequencer.sv
`timescale 1ns/1ns
`include "img_macros.svh"

module readout_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_readout,
    input  img_pkg::bank_sel_t       cmd_bank,
    input  logic [`HEADER_WIDTH-1:0] cmd_header,
    input  logic                     cmd_thumb,
    frame_bank_if.reader             banks [`BANK_COUNT],
    output logic                     readout_start,
    output logic                     readout_ready,
    input  logic                     readout_trigger,
    output img_pkg::word_t           readout_data,
    output logic                     readout_done
);

    readout_pkg::readout_state_e  state;
    img_pkg::bank_sel_t           bank_q;
    logic                         thumb_q;
    logic [`HEADER_WIDTH-1:0]     shift_q;
    logic [`SHIFT_COUNT_WIDTH-1:0] shift_cnt;
    logic                         drain_cnt;
    logic                         done_q;

    img_pkg::bank_addr_t          addr_q;
    img_pkg::bank_addr_t          rd_addr;
    img_pkg::word_t               bank_rd_data [`BANK_COUNT];
    img_pkg::word_t               pixel_word;
    img_pkg::word_t               shift_word;
    logic                         load;
    logic                         keep;
    logic                         advance;

    logic                         csum_en;
    img_pkg::word_t               csum_din;
    readout_pkg::checksum_t       csum;

    // Output register takes a word when empty or drained this cycle
    assign load = !readout_ready || readout_trigger;

    // Thumbnail keeps x and y in {0,1} mod 8; x is addr[3:0], y is addr[7:4]
    assign keep = !thumb_q || ((addr_q[2:1] == 2'b00) && (addr_q[6:5] == 2'b00));

    // Step past dropped pixels freely, kept ones only when loaded
    assign advance    = (state == readout_pkg::PIXELS) && (!keep || load);
    assign rd_addr    = advance ? addr_q + 1'b1 : addr_q;
    assign pixel_word = bank_rd_data[bank_q];
    assign shift_word = shift_q[`HEADER_WIDTH-1 -: `WORD_WIDTH];

    for (genvar b = 0; b < `BANK_COUNT; b++) begin : g_rd
        assign banks[b].rd_addr = rd_addr;
        assign bank_rd_data[b]  = banks[b].rd_data;
    end

    fletcher_checksum u_checksum (
        .clk  (clk),
        .rst  (rst),
        .clear(cmd_readout),
        .en   (csum_en),
        .din  (csum_din),
        .dout (csum)
    );

    // ========================================
    // Readout FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= readout_pkg::IDLE;
            bank_q        <= '0;
            thumb_q       <= 1'b0;
            shift_cnt     <= '0;
            drain_cnt     <= 1'b0;
            done_q        <= 1'b0;
            addr_q        <= '0;
            csum_en       <= 1'b0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
        end else begin
            readout_start <= cmd_readout;
            csum_en       <= 1'b0;
            addr_q        <= rd_addr;
            if (readout_ready && readout_trigger) readout_ready <= 1'b0;

            case (state)
                readout_pkg::IDLE: begin
                end
                readout_pkg::HEADER: begin
                    if (load) begin
                        readout_data  <= shift_word;
                        readout_ready <= 1'b1;
                        csum_en       <= 1'b1;
                        csum_din      <= shift_word;
                        shift_q       <= shift_q << `WORD_WIDTH;
                        shift_cnt     <= shift_cnt - 1'b1;
                        if (shift_cnt == 1) state <= readout_pkg::PIXELS;
                    end
                end
                readout_pkg::PIXELS: begin
                    if (keep && load) begin
                        readout_data  <= pixel_word;
                        readout_ready <= 1'b1;
                        csum_en       <= 1'b1;
                        csum_din      <= pixel_word;
                    end
                    if (advance && (addr_q == '1)) begin
                        drain_cnt <= 1'b1;
                        state     <= readout_pkg::DRAIN;
                    end
                end
                readout_pkg::DRAIN: begin
                    // Last word is still two cycles from the sum registers
                    if (drain_cnt) begin
                        drain_cnt <= 1'b0;
                    end else begin
                        shift_q <= {csum[7:0], csum[15:8], csum[23:16], csum[31:24],
                                    {(`HEADER_WIDTH - 32){1'b0}}};
                        shift_cnt <= `TRAILER_WORD_COUNT;
                        state     <= readout_pkg::TRAILER;
                    end
                end
                readout_pkg::TRAILER: begin
                    if (load) begin
                        if (shift_cnt != 0) begin
                            readout_data  <= shift_word;
                            readout_ready <= 1'b1;
                            shift_q       <= shift_q << `WORD_WIDTH;
                            shift_cnt     <= shift_cnt - 1'b1;
                        end else begin
                            // Last padding word has left the output register
                            done_q <= 1'b1;
                            state  <= readout_pkg::IDLE;
                        end
                    end
                end
                default: state <= readout_pkg::IDLE;
            endcase

            if (cmd_readout) begin
                state         <= readout_pkg::HEADER;
                bank_q        <= cmd_bank;
                thumb_q       <= cmd_thumb;
                shift_q       <= cmd_header;
                shift_cnt     <= `HEADER_WORD_COUNT;
                addr_q        <= '0;
                csum_en       <= 1'b0;
                done_q        <= 1'b0;
                readout_ready <= 1'b0;
            end
        end
    end

    assign readout_done = done_q && !cmd_readout;

    // A word offered to the host must not change until it is taken
    a_data_held: assert property (@(posedge clk) disable iff (rst)
        (readout_ready && !readout_trigger && !cmd_readout)
        |=> readout_ready && $stable(readout_data));

endmodule

//--- design/pixel_capture.sv
`timescale 1ns/1ns
`include "img_macros.svh"

module pixel_capture (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_capture,
    input  img_pkg::bank_sel_t    cmd_bank,
    input  logic                  cmd_skip_count,
    input  img_pkg::pixel_t       img_d,
    input  logic                  img_fv,
    input  logic                  img_lv,
    frame_bank_if.writer          banks [`BANK_COUNT],
    output logic                  capture_done,
    output img_pkg::pixel_count_t capture_pixel_count,
    output img_pkg::stat_t        capture_highlight_count,
    output img_pkg::stat_t        capture_shadow_count
);

    img_pkg::capture_state_e state;
    img_pkg::bank_sel_t      bank_q;
    logic                    skip_cnt;
    logic                    fv_prev;
    logic                    lv_prev;
    logic [1:0]              x_cnt;
    logic [1:0]              y_cnt;
    logic                    frame_start;

    logic                    wr_en_q;
    img_pkg::word_t          wr_data_q;
    logic                    stat_en_q;
    img_pkg::pixel_t         stat_px_q;

    img_pkg::pixel_count_t   pixel_count;
    img_pkg::stat_t          highlight_count;
    img_pkg::stat_t          shadow_count;

    assign frame_start = img_fv && !fv_prev;

    // ========================================
    // Position within the frame
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            fv_prev <= img_fv;
            lv_prev <= img_lv;
            x_cnt   <= img_lv ? x_cnt + 1'b1 : 2'd0;
            if (!img_fv) begin
                y_cnt <= '0;
            end else if (lv_prev && !img_lv) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // Little endian packing: low byte first, then the high nibble
    always_ff @(posedge clk) begin
        wr_data_q <= {img_d[7:0], 4'b0000, img_d[11:8]};
        stat_px_q <= img_d;
    end

    // ========================================
    // Capture FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= img_pkg::IDLE;
            bank_q          <= '0;
            skip_cnt        <= 1'b0;
            wr_en_q         <= 1'b0;
            stat_en_q       <= 1'b0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            capture_done <= 1'b0;
            wr_en_q      <= 1'b0;
            stat_en_q    <= 1'b0;

            if (wr_en_q) begin
                pixel_count <= pixel_count + 1'b1;
            end

            // Only the top seven bits decide highlight or shadow
            if (stat_en_q) begin
                if (&stat_px_q[11:5]) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (stat_px_q[11:5] == 7'd0) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                img_pkg::IDLE: begin
                end
                img_pkg::WAIT_FRAME: begin
                    if (frame_start) state <= img_pkg::SKIP_CHECK;
                end
                img_pkg::SKIP_CHECK: begin
                    if (skip_cnt) begin
                        skip_cnt <= skip_cnt - 1'b1;
                        state    <= img_pkg::WAIT_FRAME;
                    end else begin
                        state <= img_pkg::ACTIVE;
                    end
                end
                img_pkg::ACTIVE: begin
                    wr_en_q   <= img_lv;
                    // Sample one pixel out of every 4x4 block
                    stat_en_q <= img_lv && (x_cnt == 2'd0) && (y_cnt == 2'd0);
                    if (!img_fv) begin
                        capture_done <= 1'b1;
                        state        <= img_pkg::IDLE;
                    end
                end
                default: state <= img_pkg::IDLE;
            endcase

            // A new command restarts the capture
            if (cmd_capture) begin
                state           <= img_pkg::WAIT_FRAME;
                bank_q          <= cmd_bank;
                skip_cnt        <= cmd_skip_count;
                wr_en_q         <= 1'b0;
                stat_en_q       <= 1'b0;
                pixel_count     <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end
        end
    end

    // Write port of each bank, enabled only on the selected one
    for (genvar b = 0; b < `BANK_COUNT; b++) begin : g_wr
        assign banks[b].wr_en   = wr_en_q && (bank_q == img_pkg::bank_sel_t'(b));
        assign banks[b].wr_addr = pixel_count[`BANK_ADDR_WIDTH-1:0];
        assign banks[b].wr_data = wr_data_q;
    end

    assign capture_pixel_count     = pixel_count;
    assign capture_highlight_count = highlight_count;
    assign capture_shadow_count    = shadow_count;

    // A frame larger than the bank would wrap onto the first pixels
    a_wr_addr_in_range: assert property (@(posedge clk) disable iff (rst)
        wr_en_q |-> pixel_count < `IMG_PIXEL_COUNT);

endmodule

//--- design/fletcher_checksum.sv
`timescale 1ns/1ns

module fletcher_checksum (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  en,
    input  img_pkg::word_t        din,
    output readout_pkg::checksum_t dout
);

    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] din_swapped;
    logic [15:0] sum_a_next;

    // Addition modulo 65535
    function automatic logic [15:0] mod_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= 17'd65535) begin
            sum = sum - 17'd65535;
        end
        return sum[15:0];
    endfunction

    // Words are summed as the host sees them, low byte first
    assign din_swapped = {din[7:0], din[15:8]};
    assign sum_a_next  = mod_add(sum_a, din_swapped);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= sum_a_next;
            sum_b <= mod_add(sum_b, sum_a_next);
        end
    end

    assign dout = {sum_b, sum_a};

endmodule

//--- design/frame_bank.sv
`timescale 1ns/1ns
`include "img_macros.svh"

module frame_bank (
    input  logic        clk,
    frame_bank_if.bank  port
);

    // ========================================
    // One full frame of packed pixels
    // ========================================
    img_pkg::word_t mem [`IMG_PIXEL_COUNT];

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clk) begin
        port.rd_data <= mem[port.rd_addr];
    end

endmodule

//--- design/frame_bank_if.sv
`timescale 1ns/1ns

interface frame_bank_if;

    // Write side, from the capture block
    logic               wr_en;
    img_pkg::bank_addr_t wr_addr;
    img_pkg::word_t     wr_data;

    // Read side, to the readout block
    img_pkg::bank_addr_t rd_addr;
    img_pkg::word_t     rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport bank (
        input  wr_en, wr_addr, wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

//--- design/readout_pkg.sv
package readout_pkg;

    // ========================================
    // Readout side
    // ========================================

    // Readout FSM
    //   HEADER   shift out the header words
    //   PIXELS   walk the bank, filtered in thumbnail mode
    //   DRAIN    let the last checksum update land
    //   TRAILER  checksum words then padding
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        PIXELS,
        DRAIN,
        TRAILER
    } readout_state_e;

    // Fletcher-32 result, second sum in the upper half
    typedef logic [31:0] checksum_t;

    // Stream order of the checksum bytes on the port
    typedef enum logic {
        CSUM_NATIVE,
        CSUM_BYTE_REVERSED
    } checksum_order_e;

endpackage

//--- design/img_pkg.sv
`include "img_macros.svh"

package img_pkg;

    // ========================================
    // Data types on the capture side
    // ========================================

    // Raw sensor sample
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // Word as stored in a bank and as sent on the readout port
    typedef logic [`WORD_WIDTH-1:0] word_t;

    typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [0:0] bank_sel_t;

    // Statistics and pixel counters
    typedef logic [`STAT_WIDTH-1:0] stat_t;
    typedef logic [`PIXEL_COUNT_WIDTH-1:0] pixel_count_t;

    // Capture FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,
        SKIP_CHECK,
        ACTIVE
    } capture_state_e;

endpackage

//--- design/img_macros.svh
`ifndef IMG_MACROS_SVH
`define IMG_MACROS_SVH

// Frame geometry
`define IMG_WIDTH               16
`define IMG_HEIGHT              16
`define IMG_PIXEL_COUNT         (`IMG_WIDTH * `IMG_HEIGHT)

// Readout stream layout
`define HEADER_WORD_COUNT       4
`define PADDING_WORD_COUNT      2
`define CHECKSUM_WORD_COUNT     2
`define TRAILER_WORD_COUNT      (`CHECKSUM_WORD_COUNT + `PADDING_WORD_COUNT)

`define BANK_COUNT              2
`define STAT_WIDTH              18
`define PIXEL_WIDTH             12
`define WORD_WIDTH              16

// Derived widths
`define BANK_ADDR_WIDTH         ($clog2(`IMG_PIXEL_COUNT))
`define PIXEL_COUNT_WIDTH       ($clog2(`IMG_PIXEL_COUNT) + 1)
`define HEADER_WIDTH            (`HEADER_WORD_COUNT * `WORD_WIDTH)
`define SHIFT_COUNT_WIDTH       3

`endif
